//--- rtl/mips_isa_pkg.sv
package mips_isa_pkg;

    localparam int WORD_W  = 32;
    localparam int SHAMT_W = 5;     // sll/srl/sra amount field

    typedef logic [WORD_W-1:0] word_t;

    // operations handled by the execute stage
    typedef enum logic [4:0] {
        OP_ADD   = 5'd0,    // trapping forms flag overflow
        OP_ADDU  = 5'd1,
        OP_SUB   = 5'd2,
        OP_SUBU  = 5'd3,
        OP_AND   = 5'd4,
        OP_OR    = 5'd5,
        OP_XOR   = 5'd6,
        OP_NOR   = 5'd7,
        OP_SLT   = 5'd8,
        OP_SLTU  = 5'd9,
        OP_SLL   = 5'd10,
        OP_SRL   = 5'd11,
        OP_SRA   = 5'd12,
        OP_MULT  = 5'd13,   // multi-cycle engine from here
        OP_MULTU = 5'd14,
        OP_DIV   = 5'd15,
        OP_DIVU  = 5'd16,
        OP_MFHI  = 5'd17,   // hi/lo moves
        OP_MFLO  = 5'd18,
        OP_MTHI  = 5'd19,
        OP_MTLO  = 5'd20
    } exe_op_e;

endpackage

//--- rtl/exe_bus_pkg.sv
package exe_bus_pkg;

    import mips_isa_pkg::*;

    // request into the execute unit
    // shifts take the amount from opa and shift opb
    typedef struct packed {
        logic    valid;
        exe_op_e op;
        word_t   opa;
        word_t   opb;
    } exe_req_t;

    // registered alu output keeping the op for write-back decode
    typedef struct packed {
        logic    valid;
        exe_op_e op;
        word_t   data;
        logic    ovf;
    } alu_res_t;

    typedef struct packed {
        logic  done;    // one-cycle strobe
        word_t hi;
        word_t lo;
    } md_res_t;

    typedef struct packed {
        logic  valid;
        word_t data;
        logic  ovf;
    } exe_rsp_t;

endpackage

//--- rtl/exe_alu.sv
module exe_alu (
    input  logic                  aclk_i,
    input  logic                  rst_n_i,
    input  exe_bus_pkg::exe_req_t req_i,
    input  logic                  accept_i,
    output exe_bus_pkg::alu_res_t alu_res_o
);

    import mips_isa_pkg::*;

    logic               is_sub;
    word_t              sum;
    logic               ovf;
    logic               slt;
    logic               sltu;
    logic [SHAMT_W-1:0] shamt;
    word_t              result;

    // adder shared by add and subtract
    always_comb begin
        is_sub = (req_i.op == OP_SUB) || (req_i.op == OP_SUBU);
        sum    = is_sub ? req_i.opa - req_i.opb : req_i.opa + req_i.opb;
    end

    // signed overflow reported by the trapping forms only
    always_comb begin
        ovf = 1'b0;
        if (req_i.op == OP_ADD) begin
            ovf = (req_i.opa[WORD_W-1] == req_i.opb[WORD_W-1]) &&
                  (sum[WORD_W-1] != req_i.opa[WORD_W-1]);
        end else if (req_i.op == OP_SUB) begin
            ovf = (req_i.opa[WORD_W-1] != req_i.opb[WORD_W-1]) &&
                  (sum[WORD_W-1] != req_i.opa[WORD_W-1]);
        end
    end

    assign slt   = $signed(req_i.opa) < $signed(req_i.opb);
    assign sltu  = req_i.opa < req_i.opb;
    assign shamt = req_i.opa[SHAMT_W-1:0];      // shamt field

    always_comb begin
        case (req_i.op)
            OP_ADD, OP_ADDU,
            OP_SUB, OP_SUBU: result = sum;
            OP_AND:          result = req_i.opa & req_i.opb;
            OP_OR:           result = req_i.opa | req_i.opb;
            OP_XOR:          result = req_i.opa ^ req_i.opb;
            OP_NOR:          result = ~(req_i.opa | req_i.opb);
            OP_SLT:          result = {{(WORD_W-1){1'b0}}, slt};
            OP_SLTU:         result = {{(WORD_W-1){1'b0}}, sltu};
            OP_SLL:          result = req_i.opb << shamt;
            OP_SRL:          result = req_i.opb >> shamt;
            OP_SRA:          result = $signed(req_i.opb) >>> shamt;
            // mthi/mtlo echo opa and other ops ignore data
            default:         result = req_i.opa;
        endcase
    end

    // valid follows acceptance
    always_ff @(posedge aclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            alu_res_o <= '0;
        end else begin
            alu_res_o.valid <= accept_i;
            if (accept_i) begin
                alu_res_o.op   <= req_i.op;
                alu_res_o.data <= result;
                alu_res_o.ovf  <= ovf;
            end
        end
    end

endmodule

//--- rtl/mult_div.sv
module mult_div (
    input  logic                  aclk_i,
    input  logic                  rst_n_i,
    input  exe_bus_pkg::exe_req_t req_i,
    input  logic                  accept_i,
    output logic                  busy_o,
    output exe_bus_pkg::md_res_t  md_res_o
);

    import mips_isa_pkg::*;

    logic                  is_signed;
    logic                  start_mul;
    logic                  start_div;
    logic [2*WORD_W-1:0]   ext_a;
    logic [2*WORD_W-1:0]   ext_b;
    logic [2*WORD_W-1:0]   prod;
    word_t                 mag_a;
    word_t                 mag_b;

    logic                  busy_q;
    logic                  done_q;
    logic                  div_run_q;
    logic [5:0]            step_q;
    logic                  last_step;
    word_t                 dvs_q;       // divisor magnitude
    word_t                 quo_q;       // dividend shifts out as quotient shifts in
    word_t                 rem_q;
    logic                  neg_quo_q;
    logic                  neg_rem_q;
    word_t                 hi_q;
    word_t                 lo_q;

    logic [WORD_W:0]       rem_sh;
    logic [WORD_W+1:0]     trial;
    word_t                 quo_nxt;
    word_t                 rem_nxt;

    assign is_signed = (req_i.op == OP_MULT) || (req_i.op == OP_DIV);
    assign start_mul = accept_i && ((req_i.op == OP_MULT) || (req_i.op == OP_MULTU));
    assign start_div = accept_i && ((req_i.op == OP_DIV) || (req_i.op == OP_DIVU));

    // sign extension picks signed or unsigned product
    assign ext_a = {{WORD_W{is_signed & req_i.opa[WORD_W-1]}}, req_i.opa};
    assign ext_b = {{WORD_W{is_signed & req_i.opb[WORD_W-1]}}, req_i.opb};
    assign prod  = ext_a * ext_b;

    assign mag_a = (is_signed && req_i.opa[WORD_W-1]) ? -req_i.opa : req_i.opa;
    assign mag_b = (is_signed && req_i.opb[WORD_W-1]) ? -req_i.opb : req_i.opb;

    // one restoring step
    always_comb begin
        rem_sh = {rem_q, quo_q[WORD_W-1]};
        trial  = {1'b0, rem_sh} - {2'b00, dvs_q};
        if (!trial[WORD_W+1]) begin
            rem_nxt = trial[WORD_W-1:0];
            quo_nxt = {quo_q[WORD_W-2:0], 1'b1};
        end else begin
            rem_nxt = rem_sh[WORD_W-1:0];
            quo_nxt = {quo_q[WORD_W-2:0], 1'b0};
        end
    end

    assign last_step = div_run_q && (step_q == 6'd31);

    always_ff @(posedge aclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
            div_run_q <= 1'b0;
            step_q    <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_mul) begin
                busy_q <= 1'b1;
                done_q <= 1'b1;             // product ready next cycle
            end else if (start_div) begin
                busy_q    <= 1'b1;
                div_run_q <= 1'b1;
                step_q    <= '0;
            end else if (div_run_q) begin
                step_q <= step_q + 6'd1;
                if (last_step) begin
                    div_run_q <= 1'b0;
                    done_q    <= 1'b1;
                end
            end else if (done_q) begin
                busy_q <= 1'b0;             // ready again after the done cycle
            end
        end
    end

    always_ff @(posedge aclk_i) begin
        if (start_div) begin
            dvs_q     <= mag_b;
            quo_q     <= mag_a;
            rem_q     <= '0;
            neg_quo_q <= is_signed && (req_i.opa[WORD_W-1] ^ req_i.opb[WORD_W-1]);
            neg_rem_q <= is_signed && req_i.opa[WORD_W-1];   // follows dividend
        end else if (div_run_q) begin
            quo_q <= quo_nxt;
            rem_q <= rem_nxt;
        end
    end

    // signs applied to the result pair on the final step
    always_ff @(posedge aclk_i) begin
        if (start_mul) begin
            hi_q <= prod[2*WORD_W-1:WORD_W];
            lo_q <= prod[WORD_W-1:0];
        end else if (last_step) begin
            lo_q <= neg_quo_q ? -quo_nxt : quo_nxt;
            hi_q <= neg_rem_q ? -rem_nxt : rem_nxt;
        end
    end

    assign busy_o   = busy_q;
    assign md_res_o = '{done: done_q, hi: hi_q, lo: lo_q};

endmodule

//--- rtl/hilo_writeback.sv
module hilo_writeback (
    input  logic                  aclk_i,
    input  logic                  rst_n_i,
    input  exe_bus_pkg::alu_res_t alu_res_i,
    input  exe_bus_pkg::md_res_t  md_res_i,
    output exe_bus_pkg::exe_rsp_t rsp_o
);

    import mips_isa_pkg::*;

    word_t hi_q;
    word_t lo_q;
    logic  alu_is_md;

    // mult/div responses come from the engine's done strobe
    assign alu_is_md = (alu_res_i.op == OP_MULT) || (alu_res_i.op == OP_MULTU) ||
                       (alu_res_i.op == OP_DIV)  || (alu_res_i.op == OP_DIVU);

    always_ff @(posedge aclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (md_res_i.done) begin
            hi_q <= md_res_i.hi;
            lo_q <= md_res_i.lo;
        end else if (alu_res_i.valid) begin
            if (alu_res_i.op == OP_MTHI) begin
                hi_q <= alu_res_i.data;
            end
            if (alu_res_i.op == OP_MTLO) begin
                lo_q <= alu_res_i.data;
            end
        end
    end

    // merge both sources into one response
    always_comb begin
        rsp_o.valid = 1'b0;
        rsp_o.data  = alu_res_i.data;
        rsp_o.ovf   = 1'b0;
        if (md_res_i.done) begin
            rsp_o.valid = 1'b1;
            rsp_o.data  = md_res_i.lo;      // new lo
        end else begin
            rsp_o.valid = alu_res_i.valid && !alu_is_md;
            rsp_o.ovf   = alu_res_i.ovf;
            case (alu_res_i.op)
                OP_MFHI: rsp_o.data = hi_q;
                OP_MFLO: rsp_o.data = lo_q;
                default: rsp_o.data = alu_res_i.data;
            endcase
        end
    end

endmodule

//--- rtl/exe_unit_top.sv
module exe_unit_top (
    input  logic                  aclk_i,
    input  logic                  rst_n_i,
    input  exe_bus_pkg::exe_req_t req_i,
    output logic                  ready_o,
    output exe_bus_pkg::exe_rsp_t rsp_o
);

    import exe_bus_pkg::*;

    logic     busy;
    logic     accept;
    alu_res_t alu_res;
    md_res_t  md_res;

    assign ready_o = !busy;                     // stall while mult/div runs
    assign accept  = req_i.valid && ready_o;

    exe_alu u_exe_alu (
        .aclk_i    (aclk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (req_i),
        .accept_i  (accept),
        .alu_res_o (alu_res)
    );

    mult_div u_mult_div (
        .aclk_i   (aclk_i),
        .rst_n_i  (rst_n_i),
        .req_i    (req_i),
        .accept_i (accept),
        .busy_o   (busy),
        .md_res_o (md_res)
    );

    hilo_writeback u_hilo_writeback (
        .aclk_i    (aclk_i),
        .rst_n_i   (rst_n_i),
        .alu_res_i (alu_res),
        .md_res_i  (md_res),
        .rsp_o     (rsp_o)
    );

endmodule

//--- tb/exe_checker.sv
module exe_checker (
    input  logic                  aclk_i,
    input  logic                  rst_n_i,
    input  exe_bus_pkg::exe_req_t req_i,
    input  logic                  ready_i,
    input  exe_bus_pkg::exe_rsp_t rsp_i,
    input  logic                  group_end_i,
    input  logic [2:0]            group_id_i,
    output int                    pending_o,
    output int                    chk_cnt_o,
    output int                    err_cnt_o
);

    timeunit 1ns;
    timeprecision 1ps;

    import mips_isa_pkg::*;
    import exe_bus_pkg::*;

    typedef struct packed {
        exe_op_e     op;
        word_t       data;
        logic        ovf;
        logic [31:0] cyc;   // cycle of acceptance
    } exp_t;

    exp_t  exp_q[$];
    word_t hi_m = '0;       // model of the hi/lo pair
    word_t lo_m = '0;
    logic  md_busy = 1'b0;  // mult/div accepted and its response not yet seen
    int    cyc = 0;
    int    pending = 0;
    int    chk_cnt = 0;
    int    err_cnt = 0;
    int    grp_chk = 0;
    int    grp_err = 0;
    logic  reset_seen = 1'b0;

    assign pending_o = pending;
    assign chk_cnt_o = chk_cnt;
    assign err_cnt_o = err_cnt;

    function automatic string group_name(input logic [2:0] id);
        case (id)
            0:       return "alu_ops";
            1:       return "mult_hilo";
            2:       return "div_hilo";
            3:       return "mt_mf";
            default: return "random_mix";
        endcase
    endfunction

    // expected response of one accepted request with hi/lo updated as a side effect
    function automatic exp_t predict(input exe_req_t r);
        longint      sa;
        longint      sb;
        longint      wide;
        logic [63:0] uprod;
        exp_t        e;
        sa     = $signed(r.opa);
        sb     = $signed(r.opb);
        e.op   = r.op;
        e.data = '0;
        e.ovf  = 1'b0;
        e.cyc  = cyc;
        case (r.op)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: begin
                wide   = (r.op == OP_ADD || r.op == OP_ADDU) ? sa + sb : sa - sb;
                e.data = wide[WORD_W-1:0];
                e.ovf  = (r.op == OP_ADD || r.op == OP_SUB) &&
                         (wide > 64'sh7fff_ffff || wide < -64'sh8000_0000);
            end
            OP_AND:  e.data = r.opa & r.opb;
            OP_OR:   e.data = r.opa | r.opb;
            OP_XOR:  e.data = r.opa ^ r.opb;
            OP_NOR:  e.data = ~(r.opa | r.opb);
            OP_SLT:  e.data = (sa < sb) ? 1 : 0;
            OP_SLTU: e.data = (r.opa < r.opb) ? 1 : 0;
            OP_SLL:  e.data = r.opb << r.opa[SHAMT_W-1:0];
            OP_SRL:  e.data = r.opb >> r.opa[SHAMT_W-1:0];
            OP_SRA: begin
                wide   = sb >>> r.opa[SHAMT_W-1:0];   // sign fills from the 64-bit copy
                e.data = wide[WORD_W-1:0];
            end
            OP_MULT: begin
                wide         = sa * sb;
                {hi_m, lo_m} = wide;
            end
            OP_MULTU: begin
                uprod        = {32'b0, r.opa} * {32'b0, r.opb};
                {hi_m, lo_m} = uprod;
            end
            OP_DIV: begin
                if (r.opb == '0) begin
                    lo_m = r.opa[WORD_W-1] ? 32'd1 : '1;   // negated all ones
                    hi_m = r.opa;
                end else begin
                    wide = sa / sb;
                    lo_m = wide[WORD_W-1:0];
                    wide = sa % sb;
                    hi_m = wide[WORD_W-1:0];
                end
            end
            OP_DIVU: begin
                if (r.opb == '0) begin
                    lo_m = '1;
                    hi_m = r.opa;
                end else begin
                    lo_m = r.opa / r.opb;
                    hi_m = r.opa % r.opb;
                end
            end
            OP_MFHI: e.data = hi_m;
            OP_MFLO: e.data = lo_m;
            OP_MTHI: begin
                hi_m   = r.opa;
                e.data = r.opa;
            end
            OP_MTLO: begin
                lo_m   = r.opa;
                e.data = r.opa;
            end
            default: e.data = '0;
        endcase
        if (r.op inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU}) begin
            e.data = lo_m;
        end
        return e;
    endfunction

    task automatic compare(input string name, input word_t expv, input word_t actv);
        chk_cnt++;
        grp_chk++;
        if (actv !== expv) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, expv, actv);
            err_cnt++;
            grp_err++;
        end
    endtask

    always @(posedge aclk_i) begin
        exp_t e;
        cyc = cyc + 1;
        if (rst_n_i && !reset_seen) begin
            reset_seen = 1'b1;
            compare("rsp_o.valid", 0, rsp_i.valid);
        end
        // ready stays low from a mult/div acceptance through its response edge
        if (rst_n_i) begin
            compare("ready_o", !md_busy, ready_i);
        end
        // responses before requests so a stray strobe never meets this edge's request
        if (rst_n_i && rsp_i.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("error at %0t: response arrived with no request waiting for it",
                         $time);
                err_cnt++;
                grp_err++;
            end else begin
                e = exp_q.pop_front();
                if (e.op inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU}) begin
                    md_busy = 1'b0;
                end
                compare("rsp_o.data", e.data, rsp_i.data);
                compare("rsp_o.ovf", e.ovf, rsp_i.ovf);
                compare("rsp_o latency", (e.op inside {OP_DIV, OP_DIVU}) ? 33 : 1, cyc - e.cyc);
            end
        end
        if (rst_n_i && req_i.valid && ready_i) begin
            exp_q.push_back(predict(req_i));
            if (req_i.op inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU}) begin
                md_busy = 1'b1;
            end
        end
        pending = exp_q.size();
        if (group_end_i) begin
            $display("test %s finished: %0d checks, %0d errors",
                     group_name(group_id_i), grp_chk, grp_err);
            grp_chk = 0;
            grp_err = 0;
        end
    end

endmodule

//--- tb/tb_top.sv
module tb_top;

    timeunit 1ns;
    timeprecision 1ps;

    import mips_isa_pkg::*;
    import exe_bus_pkg::*;

    localparam int unsigned SEED        = 32'h3bfa_58ae;
    localparam int          NUM_OPS     = 400;
    localparam int          TIMEOUT_CYC = NUM_OPS * 36 + 200;   // a divide per op plus idle

    logic       aclk = 1'b0;
    logic       rst_n;
    exe_req_t   req;
    logic       ready;
    exe_rsp_t   rsp;
    logic       group_end;
    logic [2:0] group_id;
    int         pending;
    int         chk_cnt;
    int         err_cnt;
    int         cycle_cnt = 0;

    always #4 aclk = ~aclk;

    exe_unit_top dut_i (
        .aclk_i  (aclk),
        .rst_n_i (rst_n),
        .req_i   (req),
        .ready_o (ready),
        .rsp_o   (rsp)
    );

    exe_checker u_checker (
        .aclk_i      (aclk),
        .rst_n_i     (rst_n),
        .req_i       (req),
        .ready_i     (ready),
        .rsp_i       (rsp),
        .group_end_i (group_end),
        .group_id_i  (group_id),
        .pending_o   (pending),
        .chk_cnt_o   (chk_cnt),
        .err_cnt_o   (err_cnt)
    );

    always @(posedge aclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYC) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("TEST FAIL");
            $finish;
        end
    end

    // corner values about a quarter of the time
    function automatic word_t rand_operand();
        case ($urandom_range(0, 15))
            0:       return '0;
            1:       return '1;
            2:       return 32'h8000_0000;
            3:       return 32'h7fff_ffff;
            default: return $urandom();
        endcase
    endfunction

    // hold the request until an edge with ready high and idle 0..2 cycles after
    task automatic issue_op(input exe_op_e op, input word_t a, input word_t b);
        req <= '{valid: 1'b1, op: op, opa: a, opb: b};
        @(posedge aclk);
        while (!ready) @(posedge aclk);
        req.valid <= 1'b0;
        repeat ($urandom_range(0, 2)) @(posedge aclk);
    endtask

    // pulse the group end once all responses are in
    task automatic close_group(input logic [2:0] id);
        @(negedge aclk);
        while (pending != 0) @(negedge aclk);
        @(posedge aclk);
        group_id  <= id;
        group_end <= 1'b1;
        @(posedge aclk);
        group_end <= 1'b0;
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n     <= 1'b0;
        req       <= '0;
        group_end <= 1'b0;
        group_id  <= '0;
        repeat (8) @(posedge aclk);
        rst_n <= 1'b1;
        @(posedge aclk);

        repeat (100) issue_op(exe_op_e'($urandom_range(0, 12)), rand_operand(), rand_operand());
        close_group(0);

        repeat (20) begin
            issue_op(exe_op_e'($urandom_range(0, 1) ? OP_MULT : OP_MULTU),
                     rand_operand(), rand_operand());
            issue_op(OP_MFHI, $urandom(), $urandom());
            issue_op(OP_MFLO, $urandom(), $urandom());
        end
        close_group(1);

        for (int i = 0; i < 20; i++) begin
            case (i)
                0:       issue_op(OP_DIV, 32'h8000_0000, 32'hffff_ffff);
                1:       issue_op(OP_DIV, 32'hffff_fff9, '0);     // negative by zero
                2:       issue_op(OP_DIV, 32'h0000_1234, '0);
                3:       issue_op(OP_DIVU, rand_operand(), '0);
                default: issue_op(exe_op_e'($urandom_range(0, 1) ? OP_DIV : OP_DIVU),
                                  rand_operand(), rand_operand());
            endcase
            issue_op(OP_MFHI, $urandom(), $urandom());
            issue_op(OP_MFLO, $urandom(), $urandom());
        end
        close_group(2);

        repeat (15) begin
            issue_op(OP_MTHI, rand_operand(), $urandom());
            issue_op(OP_MTLO, rand_operand(), $urandom());
            issue_op(OP_MFHI, $urandom(), $urandom());
            issue_op(OP_MFLO, $urandom(), $urandom());
        end
        close_group(3);

        repeat (120) issue_op(exe_op_e'($urandom_range(0, 20)), rand_operand(), rand_operand());
        close_group(4);

        @(negedge aclk);
        $display("summary: %0d checks, %0d errors, %0d responses outstanding",
                 chk_cnt, err_cnt, pending);
        if (err_cnt == 0 && pending == 0 && chk_cnt > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- all.f
rtl/mips_isa_pkg.sv
rtl/exe_bus_pkg.sv
rtl/exe_alu.sv
rtl/mult_div.sv
rtl/hilo_writeback.sv
rtl/exe_unit_top.sv
tb/exe_checker.sv
tb/tb_top.sv
